// File: source/decim_params.svh
`ifndef DECIM_PARAMS_SVH
`define DECIM_PARAMS_SVH

// ==================================================
// Filter geometry and bus widths
// ==================================================
`define DECIM_FIR_TAPS    16       // FIR coefficient count
`define DECIM_HB_TAPS     9        // Halfband taps, always odd
`define DECIM_COEFF_W     18       // Signed coefficient width
`define DECIM_ADDR_W      8
`define DECIM_DATA_W      32

// Coefficient windows in the address map
`define DECIM_FIR_BASE    8'h00
`define DECIM_HB_BASE     8'h40

// ==================================================
// Reset default coefficients
// ==================================================
// Symmetric lowpass, taps 8..15 mirror taps 7..0
`define DECIM_FIR_DEF_0   18'h3FFD8
`define DECIM_FIR_DEF_1   18'h3FF88
`define DECIM_FIR_DEF_2   18'h000A0
`define DECIM_FIR_DEF_3   18'h00320
`define DECIM_FIR_DEF_4   18'h3FB50
`define DECIM_FIR_DEF_5   18'h3F380
`define DECIM_FIR_DEF_6   18'h01C20
`define DECIM_FIR_DEF_7   18'h07D00 // Main lobe
`define DECIM_FIR_DEF_8   18'h07D00
`define DECIM_FIR_DEF_9   18'h01C20
`define DECIM_FIR_DEF_10  18'h3F380
`define DECIM_FIR_DEF_11  18'h3FB50
`define DECIM_FIR_DEF_12  18'h00320
`define DECIM_FIR_DEF_13  18'h000A0
`define DECIM_FIR_DEF_14  18'h3FF88
`define DECIM_FIR_DEF_15  18'h3FFD8

// Halfband, every second tap from center is zero
`define DECIM_HB_DEF_0    18'h00000
`define DECIM_HB_DEF_1    18'h3F600
`define DECIM_HB_DEF_2    18'h00000
`define DECIM_HB_DEF_3    18'h09800
`define DECIM_HB_DEF_4    18'h10000 // Center tap, 0.5 in Q1.17
`define DECIM_HB_DEF_5    18'h09800
`define DECIM_HB_DEF_6    18'h00000
`define DECIM_HB_DEF_7    18'h3F600
`define DECIM_HB_DEF_8    18'h00000

`endif

// File: source/decim_cfg_pkg.sv
`include "decim_params.svh"

// Configuration side types
package decim_cfg_pkg;

    // Register address on the write port
    typedef logic [`DECIM_ADDR_W-1:0] cfg_addr_t;

    // Raw write data, wider than a coefficient
    typedef logic [`DECIM_DATA_W-1:0] cfg_data_t;

    // One filter coefficient as seen by the datapath
    typedef logic [`DECIM_COEFF_W-1:0] coeff_t;

endpackage

// File: source/decim_status_pkg.sv
// Status side types
package decim_status_pkg;

    // One flag per stage
    // Bit 2 CIC, bit 1 FIR, bit 0 halfband
    typedef logic [2:0] stage_vec_t;

    // Status byte as seen by the host
    typedef logic [7:0] status_t;

    // Error code, lower value wins on conflict
    // except address and range, which come after stage faults
    typedef enum logic [2:0] {
        ERR_NONE         = 3'd0,
        ERR_OVERFLOW     = 3'd1,
        ERR_UNDERFLOW    = 3'd2,
        ERR_INVALID_ADDR = 3'd4, // Write outside both windows
        ERR_COEFF_RANGE  = 3'd5  // Data above coefficient width
    } err_type_e;

endpackage

// File: source/decim_coeff_bank.sv
`timescale 1ns/1ns
`include "decim_params.svh"

module decim_coeff_bank (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_enable,     // Gates all writes
    input  logic                       i_cfg_valid,  // Write strobe
    input  decim_cfg_pkg::cfg_addr_t   i_cfg_addr,
    input  decim_cfg_pkg::cfg_data_t   i_cfg_data,
    output decim_cfg_pkg::coeff_t      o_fir_coeff [`DECIM_FIR_TAPS],
    output decim_cfg_pkg::coeff_t      o_hb_coeff  [`DECIM_HB_TAPS],
    output logic                       o_addr_err,   // One cycle pulse
    output logic                       o_range_err   // One cycle pulse
);

    localparam int FIR_IDX_W = $clog2(`DECIM_FIR_TAPS);
    localparam int HB_IDX_W  = $clog2(`DECIM_HB_TAPS);

    // Reset images of both banks
    localparam decim_cfg_pkg::coeff_t FIR_DEF [`DECIM_FIR_TAPS] = '{
        `DECIM_FIR_DEF_0,  `DECIM_FIR_DEF_1,  `DECIM_FIR_DEF_2,  `DECIM_FIR_DEF_3,
        `DECIM_FIR_DEF_4,  `DECIM_FIR_DEF_5,  `DECIM_FIR_DEF_6,  `DECIM_FIR_DEF_7,
        `DECIM_FIR_DEF_8,  `DECIM_FIR_DEF_9,  `DECIM_FIR_DEF_10, `DECIM_FIR_DEF_11,
        `DECIM_FIR_DEF_12, `DECIM_FIR_DEF_13, `DECIM_FIR_DEF_14, `DECIM_FIR_DEF_15
    };

    localparam decim_cfg_pkg::coeff_t HB_DEF [`DECIM_HB_TAPS] = '{
        `DECIM_HB_DEF_0, `DECIM_HB_DEF_1, `DECIM_HB_DEF_2,
        `DECIM_HB_DEF_3, `DECIM_HB_DEF_4, `DECIM_HB_DEF_5,
        `DECIM_HB_DEF_6, `DECIM_HB_DEF_7, `DECIM_HB_DEF_8
    };

    // ==================================================
    // Address decode and write checks
    // ==================================================
    decim_cfg_pkg::cfg_addr_t fir_off;   // Offset into FIR window
    decim_cfg_pkg::cfg_addr_t hb_off;    // Offset into halfband window
    logic [FIR_IDX_W-1:0]     fir_idx;
    logic [HB_IDX_W-1:0]      hb_idx;
    logic                     fir_hit;
    logic                     hb_hit;
    logic                     wr_req;    // Qualified strobe
    logic                     data_ovr;  // Bits above the coefficient set
    logic                     addr_err;
    logic                     range_err;
    logic                     wr_fir;
    logic                     wr_hb;

    assign wr_req  = i_enable & i_cfg_valid;

    // Wraps below base, so one unsigned compare covers both bounds
    assign fir_off = i_cfg_addr - `DECIM_FIR_BASE;
    assign hb_off  = i_cfg_addr - `DECIM_HB_BASE;
    assign fir_hit = fir_off < decim_cfg_pkg::cfg_addr_t'(`DECIM_FIR_TAPS);
    assign hb_hit  = hb_off < decim_cfg_pkg::cfg_addr_t'(`DECIM_HB_TAPS);
    assign fir_idx = fir_off[FIR_IDX_W-1:0];
    assign hb_idx  = hb_off[HB_IDX_W-1:0];

    assign data_ovr = |i_cfg_data[`DECIM_DATA_W-1:`DECIM_COEFF_W];

    assign addr_err  = wr_req & ~(fir_hit | hb_hit);
    assign range_err = wr_req & (fir_hit | hb_hit) & data_ovr;

    // Clean writes only, a rejected write leaves the tap alone
    assign wr_fir = wr_req & fir_hit & ~data_ovr;
    assign wr_hb  = wr_req & hb_hit & ~data_ovr;

    // ==================================================
    // Coefficient storage
    // ==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `DECIM_FIR_TAPS; i++) begin
                o_fir_coeff[i] <= FIR_DEF[i];
            end
        end else if (wr_fir) begin
            o_fir_coeff[fir_idx] <= i_cfg_data[`DECIM_COEFF_W-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `DECIM_HB_TAPS; i++) begin
                o_hb_coeff[i] <= HB_DEF[i];
            end
        end else if (wr_hb) begin
            o_hb_coeff[hb_idx] <= i_cfg_data[`DECIM_COEFF_W-1:0]; // hb_hit bounds idx
        end
    end

    // Error pulses, high for the cycle after the write edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_addr_err  <= 1'b0;
            o_range_err <= 1'b0;
        end else begin
            o_addr_err  <= addr_err;
            o_range_err <= range_err;
        end
    end

endmodule

// File: source/decim_status_regs.sv
`timescale 1ns/1ns

module decim_status_regs (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_enable,       // Low clears everything
    input  decim_status_pkg::stage_vec_t  i_stage_valid,  // Stage activity levels
    input  decim_status_pkg::stage_vec_t  i_stage_ovf,
    input  decim_status_pkg::stage_vec_t  i_stage_udf,
    input  logic                          i_addr_err,     // From coefficient bank
    input  logic                          i_range_err,    // From coefficient bank
    output decim_status_pkg::status_t     o_status,
    output logic                          o_busy,
    output logic                          o_error,
    output decim_status_pkg::err_type_e   o_err_type
);

    // ==================================================
    // Fault merging
    // ==================================================
    logic                               any_ovf;
    logic                               any_udf;
    logic                               err_next;
    decim_status_pkg::err_type_e        type_next;
    decim_status_pkg::status_t          status_next;

    assign any_ovf  = |i_stage_ovf;
    assign any_udf  = |i_stage_udf;
    assign err_next = any_ovf | any_udf | i_addr_err | i_range_err;

    // Fixed priority
    // stage faults first, then write faults
    always_comb begin
        if (any_ovf) begin
            type_next = decim_status_pkg::ERR_OVERFLOW;
        end else if (any_udf) begin
            type_next = decim_status_pkg::ERR_UNDERFLOW;
        end else if (i_addr_err) begin
            type_next = decim_status_pkg::ERR_INVALID_ADDR;
        end else if (i_range_err) begin
            type_next = decim_status_pkg::ERR_COEFF_RANGE;
        end else begin
            type_next = decim_status_pkg::ERR_NONE;
        end
    end

    // Bit 4 carries this update's error, not last cycle's
    assign status_next = {
        i_stage_valid,  // 7:5 CIC, FIR, halfband active
        err_next,       // 4
        any_ovf,        // 3
        any_udf,        // 2
        i_addr_err,     // 1
        i_range_err     // 0
    };

    // ==================================================
    // Status registers
    // ==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_status   <= '0;
            o_busy     <= 1'b0;
            o_error    <= 1'b0;
            o_err_type <= decim_status_pkg::ERR_NONE;
        end else if (!i_enable) begin
            // Disabled block reports idle
            o_status   <= '0;
            o_busy     <= 1'b0;
            o_error    <= 1'b0;
            o_err_type <= decim_status_pkg::ERR_NONE;
        end else begin
            o_status   <= status_next;
            o_busy     <= |i_stage_valid; // Any stage running
            o_error    <= err_next;
            o_err_type <= type_next;      // Aligned with o_error
        end
    end

endmodule

// File: source/decim_config_status.sv
`timescale 1ns/1ns
`include "decim_params.svh"

module decim_config_status (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_enable,
    // Coefficient write port
    input  logic                          i_cfg_valid,
    input  decim_cfg_pkg::cfg_addr_t      i_cfg_addr,
    input  decim_cfg_pkg::cfg_data_t      i_cfg_data,
    // Stage status levels
    input  decim_status_pkg::stage_vec_t  i_stage_valid,
    input  decim_status_pkg::stage_vec_t  i_stage_ovf,
    input  decim_status_pkg::stage_vec_t  i_stage_udf,
    // Coefficients to the filters
    output decim_cfg_pkg::coeff_t         o_fir_coeff [`DECIM_FIR_TAPS],
    output decim_cfg_pkg::coeff_t         o_hb_coeff  [`DECIM_HB_TAPS],
    // Status to the host
    output decim_status_pkg::status_t     o_status,
    output logic                          o_busy,
    output logic                          o_error,
    output decim_status_pkg::err_type_e   o_err_type
);

    // Write check pulses, one cycle after the offending write
    logic bank_addr_err;
    logic bank_range_err;

    // ==================================================
    // Coefficient bank
    // ==================================================
    decim_coeff_bank u_coeff_bank (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_enable),
        .i_cfg_valid (i_cfg_valid),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_data  (i_cfg_data),
        .o_fir_coeff (o_fir_coeff),
        .o_hb_coeff  (o_hb_coeff),
        .o_addr_err  (bank_addr_err),
        .o_range_err (bank_range_err)
    );

    // ==================================================
    // Status registers
    // ==================================================
    // Adds one more edge to the write error path
    decim_status_regs u_status_regs (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_enable),
        .i_stage_valid (i_stage_valid),
        .i_stage_ovf   (i_stage_ovf),
        .i_stage_udf   (i_stage_udf),
        .i_addr_err    (bank_addr_err),
        .i_range_err   (bank_range_err),
        .o_status      (o_status),
        .o_busy        (o_busy),
        .o_error       (o_error),
        .o_err_type    (o_err_type)
    );

endmodule

// File: sim/decim_config_status_chk.sv
`timescale 1ns/1ns
`include "decim_params.svh"

module decim_config_status_chk (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_enable,
    input  logic                          i_cfg_valid,
    input  decim_cfg_pkg::cfg_addr_t      i_cfg_addr,
    input  decim_cfg_pkg::cfg_data_t      i_cfg_data,
    input  decim_status_pkg::stage_vec_t  i_stage_valid,
    input  decim_status_pkg::status_t     i_status,
    input  logic                          i_busy,
    input  logic                          i_error,
    input  decim_status_pkg::err_type_e   i_err_type
);

    localparam int FIR_LO = int'(`DECIM_FIR_BASE);
    localparam int FIR_HI = FIR_LO + `DECIM_FIR_TAPS;
    localparam int HB_LO  = int'(`DECIM_HB_BASE);
    localparam int HB_HI  = HB_LO + `DECIM_HB_TAPS;

    int   fail_count = 0;   // Failed assertions so far
    logic any_valid;
    logic in_window;
    logic bad_addr_wr;       // Write outside both windows
    logic bad_range_wr;      // In-window write with wide data

    assign any_valid = |i_stage_valid;
    assign in_window = (int'(i_cfg_addr) >= FIR_LO && int'(i_cfg_addr) < FIR_HI) ||
                       (int'(i_cfg_addr) >= HB_LO && int'(i_cfg_addr) < HB_HI);
    assign bad_addr_wr  = i_enable & i_cfg_valid & ~in_window;
    assign bad_range_wr = i_enable & i_cfg_valid & in_window &
                          (|i_cfg_data[`DECIM_DATA_W-1:`DECIM_COEFF_W]);

    // ==================================================
    // Status timing
    // ==================================================
    busy_follows_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_enable |=> (i_busy == $past(any_valid)))
        else begin
            fail_count++;
            $error("Busy did not follow the stage valid levels");
        end

    disable_clears: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_enable |=> (i_status == '0 && !i_busy && !i_error &&
                       i_err_type == decim_status_pkg::ERR_NONE))
        else begin
            fail_count++;
            $error("Status not cleared while disabled");
        end

    // ==================================================
    // Error priority and write error path
    // ==================================================
    ovf_wins: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_status[3] |-> (i_err_type == decim_status_pkg::ERR_OVERFLOW))
        else begin
            fail_count++;
            $error("Overflow lost priority");
        end

    udf_over_writes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_status[3:2] == 2'b01) |-> (i_err_type == decim_status_pkg::ERR_UNDERFLOW))
        else begin
            fail_count++;
            $error("Underflow lost priority over write faults");
        end

    // Bank edge then status edge
    addr_err_two_edges: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ($past(bad_addr_wr, 2) && $past(i_enable)) |-> (i_error && i_status[1]))
        else begin
            fail_count++;
            $error("Invalid address not flagged two edges later");
        end

    range_err_two_edges: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ($past(bad_range_wr, 2) && $past(i_enable)) |-> (i_error && i_status[0]))
        else begin
            fail_count++;
            $error("Range error not flagged two edges later");
        end

endmodule

// File: sim/decim_config_status_tb.sv
`timescale 1ns/1ns
`include "decim_params.svh"

module decim_config_status_tb;

    // ==================================================
    // Run length and address windows
    // ==================================================
    localparam int N_WR  = 60;   // Clean writes
    localparam int N_BAD = 40;   // Rejected writes, every other cycle
    localparam int N_MIX = 80;   // Stage levels plus random writes
    localparam int N_OFF = 12;   // Block disabled
    localparam int TEST_CYCLES = 2 + N_WR + N_BAD + N_MIX + N_OFF + 6;
    localparam int MAX_CYCLES  = 3 * TEST_CYCLES;   // 600
    localparam int FIR_LO = int'(`DECIM_FIR_BASE);
    localparam int FIR_HI = FIR_LO + `DECIM_FIR_TAPS;
    localparam int HB_LO  = int'(`DECIM_HB_BASE);
    localparam int HB_HI  = HB_LO + `DECIM_HB_TAPS;

    logic                          clk;
    logic                          rst_n;
    logic                          enable;
    logic                          cfg_valid;
    decim_cfg_pkg::cfg_addr_t      cfg_addr;
    decim_cfg_pkg::cfg_data_t      cfg_data;
    decim_status_pkg::stage_vec_t  stage_valid;
    decim_status_pkg::stage_vec_t  stage_ovf;
    decim_status_pkg::stage_vec_t  stage_udf;
    decim_cfg_pkg::coeff_t         fir_coeff [`DECIM_FIR_TAPS];
    decim_cfg_pkg::coeff_t         hb_coeff  [`DECIM_HB_TAPS];
    decim_status_pkg::status_t     status;
    logic                          busy;
    logic                          error;
    decim_status_pkg::err_type_e   err_type;

    // Reference model state
    decim_cfg_pkg::coeff_t         fir_model [`DECIM_FIR_TAPS];
    decim_cfg_pkg::coeff_t         hb_model  [`DECIM_HB_TAPS];
    logic                          pend_addr;    // Bank pulse in flight
    logic                          pend_range;
    decim_status_pkg::status_t     exp_status;
    logic                          exp_busy;
    logic                          exp_err;
    decim_status_pkg::err_type_e   exp_type;

    logic [15:0] lfsr;
    int          errors = 0;
    int          chk_fails;
    int          cycles = 0;

    decim_config_status u_decim_config_status (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_enable      (enable),
        .i_cfg_valid   (cfg_valid),
        .i_cfg_addr    (cfg_addr),
        .i_cfg_data    (cfg_data),
        .i_stage_valid (stage_valid),
        .i_stage_ovf   (stage_ovf),
        .i_stage_udf   (stage_udf),
        .o_fir_coeff   (fir_coeff),
        .o_hb_coeff    (hb_coeff),
        .o_status      (status),
        .o_busy        (busy),
        .o_error       (error),
        .o_err_type    (err_type)
    );

    bind decim_config_status decim_config_status_chk u_chk (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_enable (i_enable),
        .i_cfg_valid (i_cfg_valid), .i_cfg_addr (i_cfg_addr), .i_cfg_data (i_cfg_data),
        .i_stage_valid (i_stage_valid), .i_status (o_status), .i_busy (o_busy),
        .i_error (o_error), .i_err_type (o_err_type)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    // Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic decim_cfg_pkg::cfg_addr_t rand_win_addr();
        logic [31:0] r;
        r = take_bits(5);
        if (r[4]) begin
            return decim_cfg_pkg::cfg_addr_t'(HB_LO + int'(r[3:0]) % `DECIM_HB_TAPS);
        end
        return decim_cfg_pkg::cfg_addr_t'(FIR_LO + int'(r[3:0]));
    endfunction

    // Lands in 0x10..0x3F or 0x80..0xFF
    function automatic decim_cfg_pkg::cfg_addr_t rand_bad_addr();
        logic [31:0] r;
        r = take_bits(8);
        if (r[7]) begin
            return decim_cfg_pkg::cfg_addr_t'(32'h80 | r);
        end
        return decim_cfg_pkg::cfg_addr_t'(32'h10 + (r & 32'h2F));
    endfunction

    function automatic decim_cfg_pkg::cfg_data_t clean_data();
        return take_bits(`DECIM_COEFF_W);
    endfunction

    function automatic decim_cfg_pkg::cfg_data_t wide_data();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = take_bits(`DECIM_DATA_W - `DECIM_COEFF_W);
        if (hi == 0) hi = 1;   // At least one bit above the coefficient
        lo = take_bits(`DECIM_COEFF_W);
        return (hi << `DECIM_COEFF_W) | lo;
    endfunction

    task automatic drive_stage_levels();
        logic [31:0] a;
        logic [31:0] b;
        stage_valid = decim_status_pkg::stage_vec_t'(take_bits(3));
        a = take_bits(3);
        b = take_bits(3);
        stage_ovf = decim_status_pkg::stage_vec_t'(a & b);   // Sparse faults
        a = take_bits(3);
        b = take_bits(3);
        stage_udf = decim_status_pkg::stage_vec_t'(a & b);
    endtask

    // ==================================================
    // Reference model and checks
    // ==================================================
    task automatic load_defaults();
        fir_model = '{
            `DECIM_FIR_DEF_0,  `DECIM_FIR_DEF_1,  `DECIM_FIR_DEF_2,  `DECIM_FIR_DEF_3,
            `DECIM_FIR_DEF_4,  `DECIM_FIR_DEF_5,  `DECIM_FIR_DEF_6,  `DECIM_FIR_DEF_7,
            `DECIM_FIR_DEF_8,  `DECIM_FIR_DEF_9,  `DECIM_FIR_DEF_10, `DECIM_FIR_DEF_11,
            `DECIM_FIR_DEF_12, `DECIM_FIR_DEF_13, `DECIM_FIR_DEF_14, `DECIM_FIR_DEF_15
        };
        hb_model = '{
            `DECIM_HB_DEF_0, `DECIM_HB_DEF_1, `DECIM_HB_DEF_2,
            `DECIM_HB_DEF_3, `DECIM_HB_DEF_4, `DECIM_HB_DEF_5,
            `DECIM_HB_DEF_6, `DECIM_HB_DEF_7, `DECIM_HB_DEF_8
        };
        pend_addr  = 1'b0;
        pend_range = 1'b0;
        exp_status = '0;
        exp_busy   = 1'b0;
        exp_err    = 1'b0;
        exp_type   = decim_status_pkg::ERR_NONE;
    endtask

    // One clock edge of the register rules
    task automatic advance_model();
        int   a;
        logic wr;
        logic in_fir;
        logic in_hb;
        logic wide;
        logic ovf;
        logic udf;
        a      = int'(cfg_addr);
        wr     = enable & cfg_valid;
        in_fir = (a >= FIR_LO) && (a < FIR_HI);
        in_hb  = (a >= HB_LO) && (a < HB_HI);
        wide   = (cfg_data[`DECIM_DATA_W-1:`DECIM_COEFF_W] != '0);
        ovf    = (stage_ovf != '0);
        udf    = (stage_udf != '0);
        if (!enable) begin
            exp_status = '0;
            exp_busy   = 1'b0;
            exp_err    = 1'b0;
            exp_type   = decim_status_pkg::ERR_NONE;
        end else begin
            exp_err  = ovf | udf | pend_addr | pend_range;   // Last edge's pulses
            exp_busy = (stage_valid != '0);
            if (ovf) exp_type = decim_status_pkg::ERR_OVERFLOW;
            else if (udf) exp_type = decim_status_pkg::ERR_UNDERFLOW;
            else if (pend_addr) exp_type = decim_status_pkg::ERR_INVALID_ADDR;
            else if (pend_range) exp_type = decim_status_pkg::ERR_COEFF_RANGE;
            else exp_type = decim_status_pkg::ERR_NONE;
            exp_status = {stage_valid, exp_err, ovf, udf, pend_addr, pend_range};
        end
        pend_addr  = wr && !(in_fir || in_hb);
        pend_range = wr && (in_fir || in_hb) && wide;
        if (wr && !wide && in_fir) fir_model[a - FIR_LO] = cfg_data[`DECIM_COEFF_W-1:0];
        if (wr && !wide && in_hb) hb_model[a - HB_LO] = cfg_data[`DECIM_COEFF_W-1:0];
    endtask

    task automatic log_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_outputs();
        for (int i = 0; i < `DECIM_FIR_TAPS; i++) begin
            assert (fir_coeff[i] == fir_model[i]) else log_error($sformatf(
                "FIR tap %0d is %h, expected %h", i, fir_coeff[i], fir_model[i]));
        end
        for (int i = 0; i < `DECIM_HB_TAPS; i++) begin
            assert (hb_coeff[i] == hb_model[i]) else log_error($sformatf(
                "halfband tap %0d is %h, expected %h", i, hb_coeff[i], hb_model[i]));
        end
        assert (status == exp_status) else log_error($sformatf(
            "status is %b, expected %b", status, exp_status));
        assert (busy == exp_busy) else log_error($sformatf(
            "busy is %b, expected %b", busy, exp_busy));
        assert (error == exp_err) else log_error($sformatf(
            "error is %b, expected %b", error, exp_err));
        assert (err_type == exp_type) else log_error($sformatf(
            "error type is %0d, expected %0d", err_type, exp_type));
    endtask

    // Edge, model update, check at +1, return at +2 for the next drive
    task automatic tick();
        @(posedge clk);
        advance_model();
        #1;
        check_outputs();
        #1;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        lfsr        = 16'd45871;
        rst_n       = 1'b0;
        enable      = 1'b0;
        cfg_valid   = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        stage_valid = '0;
        stage_ovf   = '0;
        stage_udf   = '0;
        load_defaults();
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_outputs();   // Defaults and idle status
        for (int n = 0; n < N_WR; n++) begin
            enable    = (take_bits(3) != 0);
            cfg_valid = (take_bits(2) != 0);
            cfg_addr  = rand_win_addr();
            cfg_data  = clean_data();
            tick();
        end
        enable = 1'b1;
        for (int n = 0; n < N_BAD; n++) begin
            cfg_valid = (n % 2 == 0);   // Idle gap between faults
            if (take_bits(1) != 0) begin
                cfg_addr = rand_bad_addr();
                cfg_data = clean_data();
            end else begin
                cfg_addr = rand_win_addr();
                cfg_data = wide_data();
            end
            tick();
        end
        for (int n = 0; n < N_MIX; n++) begin
            drive_stage_levels();
            cfg_valid = (take_bits(1) != 0);
            cfg_addr  = decim_cfg_pkg::cfg_addr_t'(take_bits(8));
            cfg_data  = (take_bits(1) != 0) ? wide_data() : clean_data();
            tick();
        end
        enable = 1'b0;
        for (int n = 0; n < N_OFF; n++) begin
            drive_stage_levels();
            cfg_valid = 1'b1;   // Blocked while disabled
            cfg_addr  = rand_win_addr();
            cfg_data  = clean_data();
            tick();
        end
        enable      = 1'b1;
        cfg_valid   = 1'b0;
        stage_valid = '0;
        stage_ovf   = '0;
        stage_udf   = '0;
        repeat (6) tick();
        chk_fails = u_decim_config_status.u_chk.fail_count;
        $display("Checks done with %0d model errors and %0d checker failures",
                 errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: decim_regs.f
+incdir+source
source/decim_cfg_pkg.sv
source/decim_status_pkg.sv
source/decim_coeff_bank.sv
source/decim_status_regs.sv
source/decim_config_status.sv
sim/decim_config_status_chk.sv
sim/decim_config_status_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decimator register block testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=decim_sim
LOG=sim.log

verilator --binary --timing --assert -f decim_regs.f \
    --top-module decim_config_status_tb --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

# Let the run continue past checker errors so the testbench can count them
"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "Result: failed"
    exit 1
fi
echo "Result: passed"
exit 0
